// ==== aluCore_defs.svh ====
// Data widths and Wishbone register map of the ALU coprocessor, included by RTL and testbench
`ifndef ALU_CORE_DEFS_SVH
`define ALU_CORE_DEFS_SVH

// Datapath sizes fixed by the instruction encoding
`define ALU_DATA_WIDTH   16              // Operand and result word
`define ALU_SHAMT_WIDTH  4               // Shift amount taken from operand B

// Wishbone word addresses
`define ALU_ADDR_WIDTH   3
`define ALU_REG_OPA      3'd0            // Operand A, read/write
`define ALU_REG_OPB      3'd1            // Operand B, read/write
`define ALU_REG_INSTR    3'd2            // Instruction word, write starts operation
`define ALU_REG_RESULT   3'd3            // Read only
`define ALU_REG_FLAGS    3'd4            // Read only, zero-extended

// Addresses 5 to 7 are unmapped and read back as zero

`endif

// ==== aluPkg.sv ====
// Types shared by the ALU coprocessor blocks; modules import it in their header
`include "aluCore_defs.svh"

package aluPkg;

    // Register format, funct selects the operation inside a class
    typedef struct packed {
        logic [4:0] opcode;             // Instr[15:11]
        logic [8:0] regs;               // Register fields, unused here
        logic [1:0] funct;              // Instr[1:0]
    } rTypeT;

    // Immediate format, imm5 replaces operand B
    typedef struct packed {
        logic [4:0] opcode;
        logic [5:0] regs;
        logic [4:0] imm;                // Zero-extended on use
    } iTypeT;

    typedef union packed {
        rTypeT rType;
        iTypeT iType;
    } instrWordT;

    typedef enum logic [3:0] {
        arithAdd, arithSub, arithXor, arithAndn, arithSlbi,
        arithLbi, arithSeq, arithSlt, arithSle, arithSco
    } arithOpT;

    typedef enum logic [2:0] {
        shiftSll, shiftSrl, shiftRol, shiftRor, shiftBtr
    } shiftOpT;

    typedef struct packed {
        logic    useShift;              // Take shift unit output
        arithOpT arithOp;
        shiftOpT shiftOp;
        logic    useImm;                // Operand B is imm5
        logic    illegal;               // NOP, jump, branch, unused memory slot
        logic [1:0] pad;
    } opSelT;

    typedef struct packed {
        logic [`ALU_DATA_WIDTH-1:0] a;
        logic [`ALU_DATA_WIDTH-1:0] b;
    } operandsT;

    typedef struct packed {
        logic [`ALU_DATA_WIDTH-1:0] value;
        logic                       carry;
    } unitResultT;

    typedef struct packed {
        logic zero;
        logic sign;
        logic carry;                    // Carry out of A plus B
        logic illegal;
    } flagsT;

endpackage

// ==== wbAluRegs.sv ====
// Wishbone classic slave holding operands and instruction, issues launch and serves reads
`timescale 1ns/1ps
`include "aluCore_defs.svh"

module wbAluRegs
    import aluPkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       wbCyc,
    input  logic                       wbStb,
    input  logic                       wbWe,
    input  logic [`ALU_ADDR_WIDTH-1:0] wbAdr,
    input  logic [`ALU_DATA_WIDTH-1:0] wbDatW,
    output logic [`ALU_DATA_WIDTH-1:0] wbDatR,
    output logic                       wbAck,
    output instrWordT                  instr,
    output operandsT                   regOperands,
    output logic                       launch,
    input  logic [`ALU_DATA_WIDTH-1:0] result,
    input  flagsT                      flags
);

    logic req;
    logic writeReq;

    // New request only while no ack is pending
    assign req      = wbCyc && wbStb && !wbAck;
    assign writeReq = req && wbWe;

    always_ff @(posedge clk) begin
        if (reset) begin
            wbAck  <= 1'b0;
            launch <= 1'b0;
        end else begin
            wbAck  <= req;                                          // Single-cycle ack
            launch <= writeReq && (wbAdr == `ALU_REG_INSTR);        // Start after INSTR write
        end
    end

    // Writes land on the ack edge
    always_ff @(posedge clk) begin
        if (reset) begin
            regOperands <= '0;
            instr       <= '0;
        end else if (writeReq) begin
            case (wbAdr)
                `ALU_REG_OPA:   regOperands.a <= wbDatW;
                `ALU_REG_OPB:   regOperands.b <= wbDatW;
                `ALU_REG_INSTR: instr         <= wbDatW;
                default: begin
                    // RESULT, FLAGS and unmapped writes are dropped
                end
            endcase
        end
    end

    // Master holds wbAdr until ack, so a plain mux is valid during ack
    always_comb begin
        case (wbAdr)
            `ALU_REG_OPA:    wbDatR = regOperands.a;
            `ALU_REG_OPB:    wbDatR = regOperands.b;
            `ALU_REG_INSTR:  wbDatR = instr;
            `ALU_REG_RESULT: wbDatR = result;
            `ALU_REG_FLAGS:  wbDatR = {{(`ALU_DATA_WIDTH - 4){1'b0}}, flags};
            default:         wbDatR = '0;                           // Unmapped
        endcase
    end

endmodule

// ==== instrDecode.sv ====
// Combinational decoder feeding both execution units with the operation and operand B source
`timescale 1ns/1ps
`include "aluCore_defs.svh"

module instrDecode
    import aluPkg::*;
(
    input  instrWordT instr,
    input  operandsT  regOperands,
    output opSelT     opSel,
    output operandsT  operands
);

    logic [2:0] opClass;
    logic [1:0] opLow;

    assign opClass = instr.rType.opcode[4:2];
    assign opLow   = instr.rType.opcode[1:0];

    always_comb begin
        opSel         = '0;
        opSel.arithOp = arithAdd;
        opSel.shiftOp = shiftSll;
        case (opClass)
            3'b010: begin                                           // Arithmetic immediate
                opSel.useImm = 1'b1;
                case (opLow)
                    2'b00:   opSel.arithOp = arithAdd;
                    2'b01:   opSel.arithOp = arithSub;
                    2'b10:   opSel.arithOp = arithXor;
                    default: opSel.arithOp = arithAndn;
                endcase
            end
            3'b100: begin                                           // Memory class, ST and LD add
                case (opLow)
                    2'b10:   opSel.arithOp = arithSlbi;
                    2'b11:   opSel.illegal = 1'b1;                  // Unused slot
                    default: opSel.arithOp = arithAdd;
                endcase
            end
            3'b101: begin                                           // Shift immediate
                opSel.useImm   = 1'b1;
                opSel.useShift = 1'b1;
                case (opLow)
                    2'b00:   opSel.shiftOp = shiftRol;
                    2'b01:   opSel.shiftOp = shiftSll;
                    2'b10:   opSel.shiftOp = shiftRor;
                    default: opSel.shiftOp = shiftSrl;
                endcase
            end
            3'b110: begin
                case (opLow)
                    2'b00: opSel.arithOp = arithLbi;
                    2'b01: begin
                        opSel.useShift = 1'b1;
                        opSel.shiftOp  = shiftBtr;
                    end
                    2'b10: begin                                    // Register shift by funct
                        opSel.useShift = 1'b1;
                        case (instr.rType.funct)
                            2'b00:   opSel.shiftOp = shiftRol;
                            2'b01:   opSel.shiftOp = shiftSll;
                            2'b10:   opSel.shiftOp = shiftRor;
                            default: opSel.shiftOp = shiftSrl;
                        endcase
                    end
                    default: opSel.arithOp = arithOpT'({2'b00, instr.rType.funct});
                endcase
            end
            3'b111: opSel.arithOp = arithOpT'(4'd6 + {2'b00, opLow});  // SEQ, SLT, SLE, SCO
            default: opSel.illegal = 1'b1;                          // NOP, jump, branch
        endcase
    end

    assign operands.a = regOperands.a;
    assign operands.b = opSel.useImm ?
                        {{(`ALU_DATA_WIDTH - 5){1'b0}}, instr.iType.imm} : regOperands.b;

endmodule

// ==== arithUnit.sv ====
// Arithmetic unit fed by the decoder for add, subtract, logic, byte-load and signed compares
`timescale 1ns/1ps
`include "aluCore_defs.svh"

module arithUnit
    import aluPkg::*;
(
    input  operandsT   operands,
    input  arithOpT    arithOp,
    output unitResultT res
);

    logic [`ALU_DATA_WIDTH:0]   sumFull;
    logic [`ALU_DATA_WIDTH-1:0] diff;
    logic [`ALU_DATA_WIDTH-1:0] slbiValue;
    logic                       isEqual;
    logic                       isLess;

    // Shared adder that also gives the ST and LD address
    assign sumFull = {1'b0, operands.a} + {1'b0, operands.b};

    // B minus A as B plus inverted A plus one
    assign diff = operands.b + ~operands.a + 1'b1;

    assign slbiValue = (operands.a << 8) | operands.b;

    // Signed compare of A against B
    assign isEqual = (operands.a == operands.b);
    assign isLess  = $signed(operands.a) < $signed(operands.b);

    always_comb begin
        case (arithOp)
            arithAdd:  res.value = sumFull[`ALU_DATA_WIDTH-1:0];
            arithSub:  res.value = diff;
            arithXor:  res.value = operands.a ^ operands.b;
            arithAndn: res.value = operands.a & ~operands.b;
            arithSlbi: res.value = slbiValue;
            arithLbi:  res.value = operands.b;
            arithSeq: begin
                res.value = '0;
                res.value[0] = isEqual;
            end
            arithSlt: begin
                res.value = '0;
                res.value[0] = isLess;
            end
            arithSle: begin
                res.value = '0;
                res.value[0] = isLess | isEqual;
            end
            arithSco: begin
                res.value = '0;
                res.value[0] = sumFull[`ALU_DATA_WIDTH];      // Carry as 0 or 1
            end
            default:   res.value = sumFull[`ALU_DATA_WIDTH-1:0];
        endcase
    end

    // Flag carry is reported for every operation
    assign res.carry = sumFull[`ALU_DATA_WIDTH];

endmodule

// ==== shiftUnit.sv ====
// Barrel shifter for logical shifts and rotates in four stages, plus bit reverse
`timescale 1ns/1ps
`include "aluCore_defs.svh"

module shiftUnit
    import aluPkg::*;
(
    input  operandsT   operands,
    input  shiftOpT    shiftOp,
    output unitResultT res
);

    logic [`ALU_SHAMT_WIDTH-1:0] shamt;
    logic [`ALU_DATA_WIDTH-1:0]  stage [0:`ALU_SHAMT_WIDTH];
    logic [`ALU_DATA_WIDTH-1:0]  reversed;

    // One stage moves the word by 2**k positions
    function automatic logic [`ALU_DATA_WIDTH-1:0] shiftStage(
        input logic [`ALU_DATA_WIDTH-1:0] v,
        input int                         k,
        input shiftOpT                    op
    );
        int n;
        n = 1 << k;
        case (op)
            shiftSll: return v << n;
            shiftSrl: return v >> n;
            shiftRol: return (v << n) | (v >> (`ALU_DATA_WIDTH - n));
            shiftRor: return (v >> n) | (v << (`ALU_DATA_WIDTH - n));
            default:  return v;
        endcase
    endfunction

    assign shamt = operands.b[`ALU_SHAMT_WIDTH-1:0];                 // Upper bits of B ignored

    // Stages of 1, 2, 4 and 8 bits
    always_comb begin
        stage[0] = operands.a;
        for (int k = 0; k < `ALU_SHAMT_WIDTH; k++) begin
            stage[k+1] = shamt[k] ? shiftStage(stage[k], k, shiftOp) : stage[k];
        end
    end

    always_comb begin
        for (int i = 0; i < `ALU_DATA_WIDTH; i++) begin
            reversed[i] = operands.a[`ALU_DATA_WIDTH-1-i];
        end
    end

    assign res.value = (shiftOp == shiftBtr) ? reversed : stage[`ALU_SHAMT_WIDTH];
    assign res.carry = 1'b0;                                         // No carry from shifts

endmodule

// ==== resultMerge.sv ====
// Result selection and flag forming, registered when an operation launches
`timescale 1ns/1ps
`include "aluCore_defs.svh"

module resultMerge
    import aluPkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       launch,
    input  opSelT                      opSel,
    input  unitResultT                 arithRes,
    input  unitResultT                 shiftRes,
    output logic [`ALU_DATA_WIDTH-1:0] result,
    output flagsT                      flags
);

    logic [`ALU_DATA_WIDTH-1:0] chosen;
    flagsT                      nextFlags;

    // Control-flow encodings produce zero
    assign chosen = opSel.illegal  ? '0 :
                    opSel.useShift ? shiftRes.value : arithRes.value;

    assign nextFlags.zero    = (chosen == '0);
    assign nextFlags.sign    = chosen[`ALU_DATA_WIDTH-1];
    assign nextFlags.carry   = arithRes.carry;                       // A plus B, always
    assign nextFlags.illegal = opSel.illegal;

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
            flags  <= '0;
        end else if (launch) begin                                   // One cycle after INSTR ack
            result <= chosen;
            flags  <= nextFlags;
        end
    end

endmodule

// ==== aluCore.sv ====
// Top level of the ALU coprocessor, a Wishbone slave wrapping decoder and execution units
`timescale 1ns/1ps
`include "aluCore_defs.svh"

module aluCore
    import aluPkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       wbCyc,
    input  logic                       wbStb,
    input  logic                       wbWe,
    input  logic [`ALU_ADDR_WIDTH-1:0] wbAdr,
    input  logic [`ALU_DATA_WIDTH-1:0] wbDatW,
    output logic [`ALU_DATA_WIDTH-1:0] wbDatR,
    output logic                       wbAck
);

    instrWordT                  instr;
    operandsT                   regOperands;
    operandsT                   operands;                            // After imm substitution
    opSelT                      opSel;
    unitResultT                 arithRes;
    unitResultT                 shiftRes;
    logic                       launch;
    logic [`ALU_DATA_WIDTH-1:0] result;
    flagsT                      flags;

    wbAluRegs u_regs (
        .clk(clk), .reset(reset),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
        .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck),
        .instr(instr), .regOperands(regOperands), .launch(launch),
        .result(result), .flags(flags)
    );

    instrDecode u_decode (
        .instr(instr), .regOperands(regOperands),
        .opSel(opSel), .operands(operands)
    );

    arithUnit u_arith (.operands(operands), .arithOp(opSel.arithOp), .res(arithRes));

    shiftUnit u_shift (.operands(operands), .shiftOp(opSel.shiftOp), .res(shiftRes));

    resultMerge u_merge (
        .clk(clk), .reset(reset), .launch(launch), .opSel(opSel),
        .arithRes(arithRes), .shiftRes(shiftRes),
        .result(result), .flags(flags)
    );

endmodule

// ==== tbClock.sv ====
// Free-running testbench clock for the ALU coprocessor, 40 ns period
`timescale 1ns/1ps

module tbClock (
    output logic clk
);

    localparam int halfPeriod = 20;    // ns

    initial begin
        clk = 1'b0;
    end

    always #halfPeriod clk = ~clk;

endmodule

// ==== aluCore_asserts.sv ====
// Wishbone handshake checks, attached to the ALU coprocessor top level with bind
`timescale 1ns/1ps
`include "aluCore_defs.svh"

module aluCore_asserts (
    input logic                       clk,
    input logic                       reset,
    input logic                       wbCyc,
    input logic                       wbStb,
    input logic                       wbAck,
    input logic [`ALU_DATA_WIDTH-1:0] wbDatR
);

    // Ack only answers a live request
    ackNeedsRequest: assert property (@(posedge clk) disable iff (reset)
        wbAck |-> (wbCyc && wbStb))
        else $error("wbAck high while wbCyc or wbStb is low");

    ackSingleCycle: assert property (@(posedge clk) disable iff (reset)
        wbAck |=> !wbAck)
        else $error("wbAck stayed high for two cycles");

    readDataKnown: assert property (@(posedge clk) disable iff (reset)
        wbAck |-> !$isunknown(wbDatR))
        else $error("wbDatR has unknown bits during wbAck");

endmodule

bind aluCore aluCore_asserts u_asserts (
    .clk(clk), .reset(reset), .wbCyc(wbCyc), .wbStb(wbStb),
    .wbAck(wbAck), .wbDatR(wbDatR)
);

// ==== aluCore_tb.sv ====
// Top-level directed testbench driving Wishbone cycles into the ALU coprocessor against a model
`timescale 1ns/1ps
`include "aluCore_defs.svh"

module aluCore_tb;

    localparam int ackTimeout = 16;                         // Cycles allowed per handshake

    logic                       clk;
    logic                       reset;
    logic                       wbCyc;
    logic                       wbStb;
    logic                       wbWe;
    logic [`ALU_ADDR_WIDTH-1:0] wbAdr;
    logic [`ALU_DATA_WIDTH-1:0] wbDatW;
    logic [`ALU_DATA_WIDTH-1:0] wbDatR;
    logic                       wbAck;
    logic [31:0]                lcgState;

    tbClock clkGen (.clk(clk));

    aluCore dut (
        .clk(clk), .reset(reset), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
        .wbAdr(wbAdr), .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck)
    );

    task automatic stopOnError(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic checkValue(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
        assert (actual === expected) else begin
            stopOnError($sformatf("[FAIL] t=%0t %s expected %h actual %h",
                                  $time, name, expected, actual));
        end
    endtask

    function automatic logic [15:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState[31:16];                              // Upper bits are the better ones
    endfunction

    function automatic logic [15:0] rotateLeft(input logic [15:0] v, input int amt);
        logic [15:0] r;
        for (int i = 0; i < 16; i++) begin
            r[(i + amt) % 16] = v[i];
        end
        return r;
    endfunction

    // Returns {zero, sign, carry, illegal, result}
    function automatic logic [19:0] expectedOutcome(input logic [15:0] instr,
                                                    input logic [15:0] a,
                                                    input logic [15:0] bReg);
        logic [4:0]  opc;
        logic [15:0] b;
        logic [15:0] r;
        logic [16:0] sum;
        logic [3:0]  amt;
        logic        bad;
        opc = instr[15:11];
        b   = (opc[4:2] == 3'b010 || opc[4:2] == 3'b101) ? {11'b0, instr[4:0]} : bReg;
        sum = {1'b0, a} + {1'b0, b};
        amt = b[3:0];
        bad = 1'b0;
        r   = '0;
        if (opc == 5'b11011) opc = {3'b010, instr[1:0]};     // Register ALU ops by funct
        if (opc == 5'b11010) opc = {3'b101, instr[1:0]};     // Register shifts by funct
        case (opc)
            5'b01000, 5'b10000, 5'b10001: r = sum[15:0];
            5'b01001: r = b - a;
            5'b01010: r = a ^ b;
            5'b01011: r = a & ~b;
            5'b10010: r = {a[7:0], 8'h00} | b;
            5'b10100: r = rotateLeft(a, amt);
            5'b10101: r = a << amt;
            5'b10110: r = rotateLeft(a, (16 - amt) % 16);
            5'b10111: r = a >> amt;
            5'b11000: r = b;
            5'b11001: r = {<<{a}};
            5'b11100: r = {15'b0, a == b};
            5'b11101: r = {15'b0, $signed(a) < $signed(b)};
            5'b11110: r = {15'b0, $signed(a) <= $signed(b)};
            5'b11111: r = {15'b0, sum[16]};
            default:  bad = 1'b1;                            // Control flow and STU
        endcase
        return {r == 16'h0, r[15], sum[16], bad, r};
    endfunction

    task automatic waitAck(input string what);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > ackTimeout) begin
                stopOnError($sformatf("No wbAck within %0d cycles on %s", ackTimeout, what));
            end
        end while (wbAck !== 1'b1);
    endtask

    // Hold the request through the edge that samples the ack
    task automatic endCycle();
        @(posedge clk);
        #1;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe  = 1'b0;
    endtask

    task automatic wbWrite(input logic [2:0] adr, input logic [15:0] data);
        wbCyc  = 1'b1;
        wbStb  = 1'b1;
        wbWe   = 1'b1;
        wbAdr  = adr;
        wbDatW = data;
        waitAck($sformatf("write to %0d", adr));
        endCycle();
    endtask

    task automatic wbRead(input logic [2:0] adr, output logic [15:0] data);
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe  = 1'b0;
        wbAdr = adr;
        waitAck($sformatf("read of %0d", adr));
        data = wbDatR;                                       // Valid during ack
        endCycle();
    endtask

    task automatic runOp(input logic [15:0] instr, input logic [15:0] a, input logic [15:0] b);
        logic [19:0] expected;
        logic [15:0] got;
        expected = expectedOutcome(instr, a, b);
        wbWrite(`ALU_REG_OPA, a);
        wbWrite(`ALU_REG_OPB, b);
        wbWrite(`ALU_REG_INSTR, instr);
        wbRead(`ALU_REG_RESULT, got);
        checkValue($sformatf("wbDatR RESULT instr %h", instr), expected[15:0], got);
        wbRead(`ALU_REG_FLAGS, got);
        checkValue($sformatf("wbDatR FLAGS instr %h", instr), {12'b0, expected[19:16]}, got);
    endtask

    task automatic testReset();
        logic [15:0] got;
        for (int adr = 0; adr < 5; adr++) begin
            wbRead(3'(adr), got);
            checkValue($sformatf("wbDatR reg %0d after reset", adr), 16'h0, got);
        end
    endtask

    task automatic testRegArith();
        for (int fn = 0; fn < 4; fn++) begin
            runOp({5'b11011, 9'(nextRand()), 2'(fn)}, 16'h8000, 16'h8000);   // Carry and zero
            repeat (6) runOp({5'b11011, 9'(nextRand()), 2'(fn)}, nextRand(), nextRand());
        end
    endtask

    task automatic testImmAndMemory();
        logic [4:0] memOps [4] = '{5'b10000, 5'b10001, 5'b10010, 5'b11000};
        for (int op = 0; op < 4; op++) begin
            repeat (5) runOp({3'b010, 2'(op), 11'(nextRand())}, nextRand(), nextRand());
            repeat (4) runOp({memOps[op], 11'(nextRand())}, nextRand(), nextRand());
        end
    endtask

    task automatic testShifts();
        for (int amt = 0; amt < 16; amt++) begin
            for (int op = 0; op < 4; op++) begin
                runOp({3'b101, 2'(op), 6'(nextRand()), 1'(nextRand()), 4'(amt)},
                      nextRand(), nextRand());
                runOp({5'b11010, 9'(nextRand()), 2'(op)}, nextRand(), {12'(nextRand()), 4'(amt)});
            end
        end
        repeat (4) runOp({5'b11001, 11'(nextRand())}, nextRand(), nextRand());   // BTR
    endtask

    task automatic testCompareAndIllegal();
        logic [15:0] vals [6] = '{16'h0000, 16'h0001, 16'h7FFF, 16'h8000, 16'hFFFF, 16'hFFFE};
        for (int op = 0; op < 4; op++) begin
            foreach (vals[i]) begin
                foreach (vals[j]) begin
                    runOp({3'b111, 2'(op), 11'(nextRand())}, vals[i], vals[j]);
                end
            end
        end
        for (int opc = 0; opc < 32; opc++) begin
            if (opc < 8 || opc[4:2] == 3'b011 || opc == 5'b10011) begin
                runOp({5'(opc), 11'(nextRand())}, nextRand(), nextRand());
            end
        end
    endtask

    task automatic testUnmapped();
        logic [19:0] expected;
        logic [15:0] got;
        expected = expectedOutcome({5'b11011, 11'b0}, 16'h1234, 16'h5678);
        runOp({5'b11011, 11'b0}, 16'h1234, 16'h5678);
        for (int adr = 3; adr < 8; adr++) begin
            wbWrite(3'(adr), 16'hFFFF);                      // Acked but dropped
        end
        wbRead(`ALU_REG_OPA, got);
        checkValue("wbDatR OPA after stray writes", 16'h1234, got);
        wbRead(`ALU_REG_OPB, got);
        checkValue("wbDatR OPB after stray writes", 16'h5678, got);
        wbRead(`ALU_REG_INSTR, got);
        checkValue("wbDatR INSTR after stray writes", {5'b11011, 11'b0}, got);
        wbRead(`ALU_REG_RESULT, got);
        checkValue("wbDatR RESULT after stray writes", expected[15:0], got);
        wbRead(`ALU_REG_FLAGS, got);
        checkValue("wbDatR FLAGS after stray writes", {12'b0, expected[19:16]}, got);
        for (int adr = 5; adr < 8; adr++) begin
            wbRead(3'(adr), got);
            checkValue($sformatf("wbDatR unmapped %0d", adr), 16'h0, got);
        end
    endtask

    initial begin
        wbCyc     = 1'b0;
        wbStb     = 1'b0;
        wbWe      = 1'b0;
        wbAdr     = '0;
        wbDatW    = '0;
        reset     = 1'b1;
        lcgState  = 32'd47;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        testReset();
        testRegArith();
        testImmAndMemory();
        testShifts();
        testCompareAndIllegal();
        testUnmapped();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== aluCore.f ====
+incdir+.
aluPkg.sv
wbAluRegs.sv
instrDecode.sv
arithUnit.sv
shiftUnit.sv
resultMerge.sv
aluCore.sv
tbClock.sv
aluCore_asserts.sv
aluCore_tb.sv

// ==== build.sh ====
#!/bin/sh
# Compile the ALU coprocessor testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module aluCore_tb -f aluCore.f -o simAluCore
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/simAluCore > sim.log 2>&1
runStatus=$?
cat sim.log
if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi

if grep -q "^Simulation PASSED$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
